// File: dac_sys.f
verilog/dac_sys_pkg.sv
verilog/reg_map.sv
verilog/sys_ctrl.sv
verilog/batch_source.sv
verilog/capture_buf.sv
verilog/dac_sys.sv
testbench/dac_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dac_sys_tb -f dac_sys.f \
    && ./obj_dir/Vdac_sys_tb > sim.log 2>&1 \
    || echo "build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -q "Result: PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/dac_sys_tb.sv
module dac_sys_tb import dac_sys_pkg::*; ();

    typedef struct packed {
        reg_addr_t  addr;
        reg_data_t  value;
        logic [7:0] batches;  // batches to watch or 0 to let the write settle
        logic       stop;     // stream must stay idle afterwards
    } step_t;

    localparam int N_STEPS     = 17;
    localparam int SEG_A_LAST  = 10;
    localparam int SETTLE      = 6;
    localparam int CYCLE_LIMIT = 200 * (N_STEPS + 4);

    logic      clk = 1'b0;
    logic      rst;
    host_req_t host_req;
    host_rsp_t host_rsp;
    logic      dac_credit = 1'b0;
    dac_out_t  dac_out;

    // reference model of the sample stream
    sample_t m_seed  = '0;
    int      m_scale = 0;
    int      m_n     = 0;

    reg_data_t shadow [NUM_REGS];
    int        delay_tab [256];
    int        pending [$];      // due cycles of credits owed by the DAC
    int        cycle       = 0;
    int        sent        = 0;
    int        returned    = 0;
    logic      rd_prev     = 1'b0;
    logic      credit_en   = 1'b1;
    logic      credit_en_q = 1'b1;

    step_t steps [N_STEPS] = '{
        '{REG_HALT,    16'h0001, 8'd0,  1'b1},
        '{REG_SEED,    16'h1234, 8'd0,  1'b0},
        '{REG_SCALE,   16'h0002, 8'd0,  1'b0},
        '{REG_HALT,    16'h0000, 8'd12, 1'b0},
        '{REG_HALT,    16'h0001, 8'd0,  1'b1},
        '{REG_SCALE,   16'h0014, 8'd0,  1'b0},  // above the clamp
        '{REG_SEED,    16'hfff0, 8'd0,  1'b0},  // count wraps
        '{REG_HALT,    16'h0000, 8'd10, 1'b0},
        '{REG_HALT,    16'h0001, 8'd0,  1'b1},
        '{REG_SCALE,   16'h0000, 8'd0,  1'b0},
        '{REG_HALT,    16'h0000, 8'd6,  1'b0},
        '{REG_HALT,    16'h0001, 8'd0,  1'b1},
        '{REG_BURST,   16'h0003, 8'd0,  1'b0},
        '{REG_HALT,    16'h0000, 8'd3,  1'b1},
        '{REG_HALT,    16'h0000, 8'd3,  1'b1},
        '{REG_CAP_ARM, 16'h0001, 8'd0,  1'b0},
        '{REG_HALT,    16'h0000, 8'd3,  1'b1}
    };

    dac_sys UUT (
        .clk        (clk),
        .rst        (rst),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .dac_credit (dac_credit),
        .dac_out    (dac_out)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic sample_t expected_sample(int n, int i);
        sample_t raw;
        raw = m_seed + sample_t'(4 * n + i);
        return raw >> m_scale;
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_batches(int n);
        int target;
        target = sent + n;
        while (sent < target) @(negedge clk);
    endtask

    task automatic expect_stopped();
        int base;
        base = sent;
        wait_cycles(12);
        check_value("batches while stopped", sent, base);
    endtask

    task automatic write_reg(reg_addr_t addr, reg_data_t data);
        @(negedge clk);
        host_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(negedge clk);
        host_req = '0;
        if (addr != REG_CAP_DATA && addr != REG_CAP_VALID) shadow[addr] = data;
    endtask

    task automatic read_reg(reg_addr_t addr, output reg_data_t data);
        @(negedge clk);
        host_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
        @(negedge clk);
        host_req = '0;
        check_value("host_rsp.valid", host_rsp.valid, 1);
        data = host_rsp.rdata;
    endtask

    task automatic check_regs();
        reg_data_t v;
        for (int a = REG_RST; a <= REG_CAP_ARM; a++) begin
            read_reg(reg_addr_t'(a), v);
            check_value($sformatf("reg[%0d]", a), v, shadow[a]);
        end
    endtask

    task automatic run_steps(int first, int last);
        step_t s;
        for (int k = first; k <= last; k++) begin
            s = steps[k];
            write_reg(s.addr, s.value);
            if (s.addr == REG_SEED) begin  // only written while halted
                m_seed = s.value;
                m_n    = 0;
            end
            if (s.addr == REG_SCALE) begin
                m_scale = (s.value > MAX_SCALE) ? MAX_SCALE : int'(s.value);
            end
            if (s.batches != 0) wait_batches(s.batches);
            else wait_cycles(SETTLE);
            if (s.stop) expect_stopped();
        end
    endtask

    // batch checks, response timing, credit bookkeeping
    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            if (cycle > CYCLE_LIMIT) begin
                $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
                abort_run();
            end
            check_value("host_rsp.valid", host_rsp.valid, rd_prev);
            if (dac_credit) returned++;
            if (dac_out.valid) begin
                for (int i = 0; i < BATCH_SAMPLES; i++) begin
                    check_value($sformatf("dac_out.batch[%0d]", i), dac_out.batch[i],
                                expected_sample(m_n, i));
                end
                pending.push_back(cycle + delay_tab[sent % 256]);
                m_n++;
                sent++;
                if (sent - returned > DAC_CREDITS) begin
                    $display("more batches in flight than the DAC gave credits for");
                    abort_run();
                end
            end
        end
        rd_prev     = host_req.rd;
        credit_en_q = credit_en;
    end

    // the DAC returns one credit per consumed batch after a random delay
    always @(negedge clk) begin
        dac_credit = 1'b0;
        if (credit_en_q && pending.size() != 0 && pending[0] <= cycle) begin
            void'(pending.pop_front());
            dac_credit = 1'b1;
        end
    end

    initial begin
        reg_data_t v;
        int        n0;
        void'($urandom(36459));
        for (int i = 0; i < 256; i++) delay_tab[i] = 1 + ($urandom % 6);
        for (int a = 0; a < NUM_REGS; a++) shadow[a] = '0;
        rst      = 1'b1;
        host_req = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // host writes to the capture registers go nowhere
        write_reg(REG_CAP_DATA, 16'hdead);
        write_reg(REG_CAP_VALID, 16'hbeef);
        read_reg(REG_CAP_DATA, v);
        check_value("cap_data", v, 0);
        read_reg(REG_CAP_VALID, v);
        check_value("cap_valid", v, 0);

        run_steps(0, SEG_A_LAST);
        check_regs();

        // hold back all credits, then release them late
        credit_en = 1'b0;
        wait_cycles(20);
        check_value("batches in flight", sent - returned, DAC_CREDITS);
        expect_stopped();
        credit_en = 1'b1;
        wait_batches(12);

        run_steps(SEG_A_LAST + 1, N_STEPS - 1);

        // the last burst of 3 was captured
        n0 = m_n - 3;
        for (int k = 0; k < 3; k++) begin
            v = '0;
            while (v != 16'd1) read_reg(REG_CAP_VALID, v);
            read_reg(REG_CAP_DATA, v);
            check_value("cap_data", v, expected_sample(n0 + k, 0));
        end
        wait_cycles(4);
        read_reg(REG_CAP_VALID, v);
        check_value("cap_valid", v, 0);

        // soft reset with every credit home
        while (sent != returned) @(negedge clk);
        write_reg(REG_BURST, 16'h0000);
        wait_cycles(SETTLE);
        credit_en = 1'b0;
        write_reg(REG_RST, 16'h0001);
        m_n = 0;  // stream still halted here
        wait_batches(DAC_CREDITS);
        expect_stopped();
        check_value("batches in flight", sent - returned, DAC_CREDITS);
        credit_en = 1'b1;
        wait_batches(8);
        check_regs();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verilog/dac_sys.sv
module dac_sys import dac_sys_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  host_req_t host_req,
    output host_rsp_t host_rsp,
    input  logic      dac_credit,
    output dac_out_t  dac_out
);

    reg_vec_t            values;
    logic [NUM_REGS-1:0] fresh;
    logic [NUM_REGS-1:0] rd_strobe;
    logic                soft_rst;
    logic                blk_rst;
    logic                halt;
    logic [3:0]          scale;
    burst_t              burst;
    sample_t             seed;
    logic                seed_load;
    logic                cap_arm;
    logic                host_pulled;
    logic                cap_data_wr;
    logic                cap_valid_wr;
    reg_data_t           cap_data_wd;
    reg_data_t           cap_valid_wd;

    assign blk_rst = rst || soft_rst;  // register storage keeps rst only

    // the host read that takes the capture data flag down
    assign host_pulled = host_req.rd
                         && host_req.addr == REG_CAP_DATA
                         && fresh[REG_CAP_DATA];

    reg_map u_reg_map (
        .clk          (clk),
        .rst          (rst),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .values       (values),
        .fresh        (fresh),
        .rd_strobe    (rd_strobe),
        .cap_data_wr  (cap_data_wr),
        .cap_valid_wr (cap_valid_wr),
        .cap_data_wd  (cap_data_wd),
        .cap_valid_wd (cap_valid_wd)
    );

    sys_ctrl u_sys_ctrl (
        .clk       (clk),
        .rst       (blk_rst),
        .values    (values),
        .fresh     (fresh),
        .rd_strobe (rd_strobe),
        .dac_valid (dac_out.valid),
        .soft_rst  (soft_rst),
        .halt      (halt),
        .scale     (scale),
        .burst     (burst),
        .seed      (seed),
        .seed_load (seed_load),
        .cap_arm   (cap_arm)
    );

    batch_source u_batch_source (
        .clk        (clk),
        .rst        (blk_rst),
        .halt       (halt),
        .scale      (scale),
        .seed       (seed),
        .seed_load  (seed_load),
        .dac_credit (dac_credit),
        .dac_out    (dac_out)
    );

    capture_buf u_capture_buf (
        .clk          (clk),
        .rst          (blk_rst),
        .arm          (cap_arm),
        .burst        (burst),
        .dac_out      (dac_out),
        .host_pulled  (host_pulled),
        .cap_data_wr  (cap_data_wr),
        .cap_valid_wr (cap_valid_wr),
        .cap_data_wd  (cap_data_wd),
        .cap_valid_wd (cap_valid_wd)
    );

endmodule

// File: verilog/capture_buf.sv
module capture_buf import dac_sys_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      arm,
    input  burst_t    burst,
    input  dac_out_t  dac_out,
    input  logic      host_pulled,
    output logic      cap_data_wr,
    output logic      cap_valid_wr,
    output reg_data_t cap_data_wd,
    output reg_data_t cap_valid_wd
);

    typedef enum logic [1:0] {C_SEND, C_WRITE_WAIT, C_POLL} deliver_state_t;

    deliver_state_t state;
    sample_t        mem [CAP_DEPTH];
    logic           armed;
    burst_t         cap_len;
    burst_t         wr_cnt;   // samples captured since arm
    burst_t         rd_ptr;   // samples handed to host

    // hand over the next sample once it has been captured
    assign cap_data_wr  = (state == C_SEND) && (rd_ptr != wr_cnt);
    assign cap_data_wd  = reg_data_t'(mem[cap_addr_t'(rd_ptr)]);
    // valid drops as soon as the host pulls, rises again with the next sample
    assign cap_valid_wr = cap_data_wr || (state == C_POLL && host_pulled);
    assign cap_valid_wd = reg_data_t'(cap_data_wr);

    always_ff @(posedge clk) begin
        if (armed && dac_out.valid) begin
            mem[cap_addr_t'(wr_cnt)] <= dac_out.batch[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            armed   <= 1'b0;
            cap_len <= '0;
            wr_cnt  <= '0;
            rd_ptr  <= '0;
            state   <= C_SEND;
        end else if (arm) begin
            armed   <= 1'b1;
            cap_len <= (burst == '0) ? burst_t'(CAP_DEPTH) : burst;
            wr_cnt  <= '0;
            rd_ptr  <= '0;
            state   <= C_SEND;
        end else begin
            if (armed && dac_out.valid) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt + 1'b1 == cap_len) armed <= 1'b0;  // buffer done
            end

            case (state)
                C_SEND: begin
                    if (cap_data_wr) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= C_WRITE_WAIT;
                    end
                end
                C_WRITE_WAIT: state <= C_POLL;  // let the fresh flag rise
                default: begin
                    if (host_pulled) state <= C_SEND;
                end
            endcase
        end
    end

endmodule

// File: verilog/batch_source.sv
module batch_source import dac_sys_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       halt,
    input  logic [3:0] scale,
    input  sample_t    seed,
    input  logic       seed_load,
    input  logic       dac_credit,
    output dac_out_t   dac_out
);

    sample_t count;    // sample 0 of the current batch
    credit_t credits;
    logic    send;

    assign send = (credits != '0) && !halt;

    always_comb begin
        dac_out.valid = send;
        for (int i = 0; i < BATCH_SAMPLES; i++) begin
            dac_out.batch[i] = sample_t'(count + sample_t'(i)) >> scale;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= seed;  // restart from stored seed
            credits <= credit_t'(DAC_CREDITS);
        end else begin
            if (seed_load) begin
                count <= seed;
            end else if (send) begin
                count <= count + sample_t'(BATCH_SAMPLES);
            end

            case ({send, dac_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // none, or one out and one back
            endcase
        end
    end

    // DAC must not hand back more credits than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst) credits <= DAC_CREDITS
    );

endmodule

// File: verilog/sys_ctrl.sv
module sys_ctrl import dac_sys_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  reg_vec_t            values,
    input  logic [NUM_REGS-1:0] fresh,
    output logic [NUM_REGS-1:0] rd_strobe,
    input  logic                dac_valid,
    output logic                soft_rst,
    output logic                halt,
    output logic [3:0]          scale,
    output burst_t              burst,
    output sample_t             seed,
    output logic                seed_load,
    output logic                cap_arm
);

    typedef enum logic [1:0] {R_IDLE, R_WAIT, R_FIRE} rst_state_t;
    typedef enum logic [1:0] {P_READ, P_WAIT, P_APPLY} param_state_t;

    rst_state_t                  rst_state;
    param_state_t                pstate [REG_HALT:REG_CAP_ARM];
    logic [REG_CAP_ARM:REG_HALT] apply;
    burst_t                      burst_cnt;
    logic                        burst_end;

    function automatic logic [3:0] clamp_scale(reg_data_t v);
        return (v > MAX_SCALE) ? 4'(MAX_SCALE) : v[3:0];
    endfunction

    function automatic burst_t clamp_burst(reg_data_t v);
        return (v > CAP_DEPTH) ? burst_t'(CAP_DEPTH) : v[3:0];
    endfunction

    always_comb begin
        for (int r = REG_HALT; r <= REG_CAP_ARM; r++) begin
            apply[r] = (pstate[r] == P_APPLY);
        end
    end

    assign soft_rst  = (rst_state == R_FIRE);
    assign seed      = values[REG_SEED];
    assign seed_load = apply[REG_SEED];
    assign cap_arm   = apply[REG_CAP_ARM] && values[REG_CAP_ARM] != '0;
    assign burst_end = dac_valid && burst != '0 && burst_cnt == burst - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            rst_state <= R_IDLE;
            for (int r = REG_HALT; r <= REG_CAP_ARM; r++) begin
                pstate[r] <= P_READ;
            end
            rd_strobe <= '0;
            halt      <= 1'b0;
            burst_cnt <= '0;
            // scale and burst reload from the register map
            scale     <= clamp_scale(values[REG_SCALE]);
            burst     <= clamp_burst(values[REG_BURST]);
        end else begin
            rd_strobe <= '0;

            case (rst_state)
                R_IDLE: begin
                    if (fresh[REG_RST]) begin
                        rd_strobe[REG_RST] <= 1'b1;
                        rst_state          <= R_WAIT;
                    end
                end
                R_WAIT:  rst_state <= R_FIRE;
                default: rst_state <= R_IDLE;
            endcase

            // read, wait, apply for each parameter register
            for (int r = REG_HALT; r <= REG_CAP_ARM; r++) begin
                case (pstate[r])
                    P_READ: begin
                        if (fresh[r]) begin
                            rd_strobe[r] <= 1'b1;
                            pstate[r]    <= P_WAIT;
                        end
                    end
                    P_WAIT:  pstate[r] <= P_APPLY;
                    default: pstate[r] <= P_READ;
                endcase
            end

            if (apply[REG_SCALE]) scale <= clamp_scale(values[REG_SCALE]);

            if (apply[REG_BURST]) begin
                burst     <= clamp_burst(values[REG_BURST]);
                burst_cnt <= '0;
            end else if (dac_valid && burst != '0) begin
                burst_cnt <= burst_end ? '0 : burst_cnt + 1'b1;
            end

            if (apply[REG_HALT]) halt <= (values[REG_HALT] != '0);
            if (burst_end) halt <= 1'b1;  // stays up until host writes 0
        end
    end

    // no update pending, so scale holds the clamped register value
    a_scale_clamped: assert property (
        @(posedge clk) disable iff (rst)
        (pstate[REG_SCALE] == P_READ && !fresh[REG_SCALE])
            |-> scale == clamp_scale(values[REG_SCALE])
    );

endmodule

// File: verilog/reg_map.sv
module reg_map import dac_sys_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  host_req_t           host_req,
    output host_rsp_t           host_rsp,
    output reg_vec_t            values,
    output logic [NUM_REGS-1:0] fresh,
    input  logic [NUM_REGS-1:0] rd_strobe,
    input  logic                cap_data_wr,
    input  logic                cap_valid_wr,
    input  reg_data_t           cap_data_wd,
    input  reg_data_t           cap_valid_wd
);

    logic      host_wr_ok;
    logic      host_pull;
    logic      rsp_valid;
    reg_data_t rsp_data;

    // capture registers are read only from the host side
    assign host_wr_ok = host_req.wr
                        && host_req.addr != REG_CAP_DATA
                        && host_req.addr != REG_CAP_VALID;
    assign host_pull  = host_req.rd && host_req.addr == REG_CAP_DATA;

    assign host_rsp = '{valid: rsp_valid, rdata: rsp_data};

    always_ff @(posedge clk) begin
        if (rst) begin
            values    <= '0;
            fresh     <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= host_req.rd;
            fresh     <= fresh & ~rd_strobe;
            if (host_pull) begin
                fresh[REG_CAP_DATA] <= 1'b0;  // host consumed the sample
            end
            if (host_wr_ok) begin
                values[host_req.addr] <= host_req.wdata;
                fresh[host_req.addr]  <= 1'b1;
            end
            if (cap_data_wr) begin
                values[REG_CAP_DATA] <= cap_data_wd;
                fresh[REG_CAP_DATA]  <= 1'b1;  // new sample wins over a pull
            end
            if (cap_valid_wr) begin
                values[REG_CAP_VALID] <= cap_valid_wd;
            end
        end
    end

    // read data lands one cycle after rd
    always_ff @(posedge clk) begin
        rsp_data <= values[host_req.addr];
    end

    a_host_one_op: assert property (
        @(posedge clk) disable iff (rst) !(host_req.wr && host_req.rd)
    );

endmodule

// File: verilog/dac_sys_pkg.sv
package dac_sys_pkg;

    localparam int BATCH_SAMPLES = 4;
    localparam int NUM_REGS      = 8;
    localparam int MAX_SCALE     = 15;
    localparam int CAP_DEPTH     = 8;
    localparam int DAC_CREDITS   = 4;

    typedef logic [15:0] sample_t;
    typedef sample_t [BATCH_SAMPLES-1:0] batch_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [2:0] reg_addr_t;
    typedef reg_data_t [NUM_REGS-1:0] reg_vec_t;
    typedef logic [3:0] burst_t;  // 0 means unlimited
    typedef logic [$clog2(DAC_CREDITS):0] credit_t;
    typedef logic [$clog2(CAP_DEPTH)-1:0] cap_addr_t;

    // register map
    localparam reg_addr_t REG_RST       = 3'd0;
    localparam reg_addr_t REG_HALT      = 3'd1;
    localparam reg_addr_t REG_BURST     = 3'd2;
    localparam reg_addr_t REG_SCALE     = 3'd3;
    localparam reg_addr_t REG_SEED      = 3'd4;
    localparam reg_addr_t REG_CAP_ARM   = 3'd5;
    localparam reg_addr_t REG_CAP_DATA  = 3'd6;  // written by capture_buf
    localparam reg_addr_t REG_CAP_VALID = 3'd7;  // written by capture_buf, no flag

    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } host_req_t;

    typedef struct packed {
        logic      valid;
        reg_data_t rdata;
    } host_rsp_t;

    typedef struct packed {
        logic   valid;
        batch_t batch;
    } dac_out_t;

endpackage
